// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = knight_tour_tb
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+.
knight_pkg.sv
tour_board.sv
tour_logic.sv
move_log.sv
tour_apb_regs.sv
knight_tour_top.sv
tb_clock_gen.sv
knight_tour_tb.sv

// ==== knight_pkg.sv ====
`default_nettype none

`include "knight_settings.svh"

package knight_pkg;

    typedef enum logic [2:0] {
        S_IDLE, S_INIT, S_SELECT, S_ADVANCE, S_BACKTRACK, S_DONE
    } solver_state_t;

    typedef enum logic [1:0] {
        RES_NONE    = 2'd0,
        RES_FOUND   = 2'd1,
        RES_NO_TOUR = 2'd2
    } tour_result_t;

    typedef enum logic [7:0] {
        ADDR_CTRL      = `REG_CTRL,
        ADDR_START     = `REG_START,
        ADDR_STATUS    = `REG_STATUS,
        ADDR_MOVE_BASE = `REG_MOVE_BASE
    } reg_addr_t;

    typedef logic [7:0] move_code_t;   // One-hot jump

    // Jump deltas, jump 0 is (-2,-1), then clockwise
    localparam logic signed [3:0] jump_dx [8] = '{-2, -1,  1,  2, 2, 1, -1, -2};
    localparam logic signed [3:0] jump_dy [8] = '{-1, -2, -2, -1, 1, 2,  2,  1};

    function automatic logic [`STEP_W-1:0] sq_index(input logic [`COORD_W-1:0] x,
                                                     input logic [`COORD_W-1:0] y);
        int idx;
        idx = int'(y) * `BOARD_DIM + int'(x);
        return idx[`STEP_W-1:0];
    endfunction

    function automatic logic on_board(input logic signed [4:0] x,
                                      input logic signed [4:0] y);
        return (x >= 0) && (x < `BOARD_DIM) && (y >= 0) && (y < `BOARD_DIM);
    endfunction

    function automatic logic [2:0] code_to_jump(input move_code_t code);
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < 8; i++) begin
            if (code[i])
                idx = i[2:0];
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// ==== knight_settings.svh ====
`ifndef KNIGHT_SETTINGS_SVH
`define KNIGHT_SETTINGS_SVH

// Board geometry
`define BOARD_DIM    5
`define NUM_SQUARES  25
`define NUM_MOVES    24            // Moves in an open tour
`define STEP_W       5             // Step index, also square index
`define COORD_W      3

// One log and tried-mask entry per move
`define STACK_DEPTH  `NUM_MOVES

// APB register offsets
`define REG_CTRL      8'h00
`define REG_START     8'h04
`define REG_STATUS    8'h08
`define REG_MOVE_BASE 8'h40        // Move i at base + 4*i

`endif

// ==== knight_tour_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module knight_tour_tb;
    import knight_pkg::*;

    localparam int NUM_TESTS   = 13;
    localparam int TEST_CYCLES = 400000;
    localparam int CLK_NS      = 4;
    localparam int POLL_LIMIT  = 100000;
    localparam int REF_LIMIT   = 20000000;

    // Jump order of the solver with (-2,-1) first
    localparam int step_dx [8] = '{-2, -1,  1,  2, 2, 1, -1, -2};
    localparam int step_dy [8] = '{-1, -2, -2, -1, 1, 2,  2,  1};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        tour_done;

    int          errors;
    int          tests_run;
    int          errs_at_start;
    logic [31:0] lcg_state;
    logic [7:0]  exp_code [`NUM_MOVES];
    logic [7:0]  got_code [`NUM_MOVES];

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk(clk));

    knight_tour_top DUT (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .tour_done
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic in_bounds(input int x, input int y);
        return (x >= 0) && (x < `BOARD_DIM) && (y >= 0) && (y < `BOARD_DIM);
    endfunction

    // Software Warnsdorff search with depth-first backtracking that fills exp_code
    function automatic int ref_tour(input int sx, input int sy);
        logic       vis [`NUM_SQUARES];
        logic [7:0] tried [`NUM_MOVES];
        int         jump [`NUM_MOVES];
        int         cx, cy, nx, ny, mx, my;
        int         s, best, min_deg, deg, iter;
        if (((sx + sy) % 2) != 0 || !in_bounds(sx, sy))
            return int'(RES_NO_TOUR);
        for (int q = 0; q < `NUM_SQUARES; q++)
            vis[q] = 1'b0;
        cx = sx;
        cy = sy;
        vis[cy * `BOARD_DIM + cx] = 1'b1;
        s = 0;
        tried[0] = '0;
        iter = 0;
        while (s < `NUM_MOVES) begin
            iter++;
            if (iter > REF_LIMIT)
                return int'(RES_NONE);
            best = -1;
            min_deg = 9;
            for (int j = 0; j < 8; j++) begin
                nx = cx + step_dx[j];
                ny = cy + step_dy[j];
                if (in_bounds(nx, ny) && !vis[ny * `BOARD_DIM + nx] && !tried[s][j]) begin
                    deg = 0;
                    for (int k = 0; k < 8; k++) begin
                        mx = nx + step_dx[k];
                        my = ny + step_dy[k];
                        if (in_bounds(mx, my) && !vis[my * `BOARD_DIM + mx])
                            deg++;
                    end
                    if (deg < min_deg) begin       // Strict so the lowest index wins a tie
                        min_deg = deg;
                        best = j;
                    end
                end
            end
            if (best >= 0) begin
                tried[s][best] = 1'b1;
                jump[s] = best;
                exp_code[s] = 8'b1 << best;
                cx = cx + step_dx[best];
                cy = cy + step_dy[best];
                vis[cy * `BOARD_DIM + cx] = 1'b1;
                s++;
                if (s < `NUM_MOVES)
                    tried[s] = '0;
            end else begin
                if (s == 0)
                    return int'(RES_NO_TOUR);
                vis[cy * `BOARD_DIM + cx] = 1'b0;   // Abandon this square
                s--;
                cx = cx - step_dx[jump[s]];
                cy = cy - step_dy[jump[s]];
            end
        end
        return int'(RES_FOUND);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Setup on one edge and access on the next with sampling at the falling edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        if (!pready)
            report_mismatch($sformatf("pready low in the write access to %02h", addr));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        if (!pready)
            report_mismatch($sformatf("pready low in the read access to %02h", addr));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic begin_test();
        errs_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == errs_at_start)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - errs_at_start);
    endtask

    task automatic start_tour(input int sx, input int sy);
        logic err;
        apb_write(`REG_START, (32'(sy) << 4) | 32'(sx), err);
        if (err)
            report_failure("write of the start square was refused with an error response");
        apb_write(`REG_CTRL, 32'h1, err);
        if (err)
            report_failure("go write on an idle solver was refused with an error response");
    endtask

    // Polls STATUS until done and then checks the result and the move window
    task automatic finish_tour(input int sx, input int sy);
        logic [31:0] status;
        logic [31:0] rd;
        logic        err;
        int          exp_res;
        int          polls;
        exp_res = ref_tour(sx, sy);
        status  = '0;
        polls   = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            apb_read(`REG_STATUS, status, err);
            polls++;
        end
        if (!status[1]) begin
            report_failure($sformatf("solver never reported done for start (%0d,%0d)", sx, sy));
            return;
        end
        if (int'(status[5:4]) != exp_res)
            report_mismatch($sformatf("start (%0d,%0d) result %0d, expected %0d",
                                      sx, sy, status[5:4], exp_res));
        if (status[0])
            report_mismatch("busy still set together with done");
        if (exp_res != int'(RES_FOUND))
            return;
        for (int i = 0; i < `NUM_MOVES; i++) begin
            apb_read(8'(`REG_MOVE_BASE + 4 * i), rd, err);
            got_code[i] = rd[7:0];
            if (err)
                report_failure($sformatf("read of move %0d gave an error response", i));
            if (rd != {24'b0, exp_code[i]})
                report_mismatch($sformatf("start (%0d,%0d) move %0d code %02h, expected %02h",
                                          sx, sy, i, rd, exp_code[i]));
        end
    endtask

    // Walks the read-back codes and counts visits per square
    task automatic check_replay(input int sx, input int sy);
        int seen [`NUM_SQUARES];
        int x, y, j;
        for (int q = 0; q < `NUM_SQUARES; q++)
            seen[q] = 0;
        x = sx;
        y = sy;
        seen[y * `BOARD_DIM + x] = 1;
        for (int i = 0; i < `NUM_MOVES; i++) begin
            if (!$onehot(got_code[i])) begin
                report_failure($sformatf("move %0d code is not one-hot", i));
                return;
            end
            j = 0;
            for (int b = 0; b < 8; b++)
                if (got_code[i][b])
                    j = b;
            x = x + step_dx[j];
            y = y + step_dy[j];
            if (!in_bounds(x, y)) begin
                report_failure($sformatf("move %0d jumps off the board", i));
                return;
            end
            seen[y * `BOARD_DIM + x]++;
        end
        for (int q = 0; q < `NUM_SQUARES; q++)
            if (seen[q] != 1)
                report_mismatch($sformatf("square %0d visited %0d times", q, seen[q]));
    endtask

    initial begin : watchdog
        #(NUM_TESTS * TEST_CYCLES * CLK_NS);
        $display("watchdog expired, the run did not finish within its time budget");
        $display("test failed");
        $finish;
    end

    initial begin : main_seq
        logic [31:0] rd;
        logic [31:0] start_before;
        logic [31:0] status_before;
        logic [31:0] move0_before;
        logic        err;
        int          sx, sy;
        errors    = 0;
        tests_run = 0;
        lcg_state = 32'h5bf5_3d6b;
        rst_n   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        apb_read(`REG_STATUS, rd, err);
        if (rd != 32'h0 || err)
            report_mismatch($sformatf("STATUS after reset reads %08h", rd));
        apb_read(`REG_START, rd, err);
        if (rd != 32'h0 || err)
            report_mismatch($sformatf("START after reset reads %08h", rd));
        apb_read(`REG_CTRL, rd, err);
        if (rd != 32'h0 || err)
            report_mismatch($sformatf("CTRL after reset reads %08h", rd));
        end_test("reset values");

        begin_test();
        start_tour(0, 0);
        finish_tour(0, 0);
        check_replay(0, 0);
        end_test("tour from (0,0)");

        for (int t = 0; t < 8; t++) begin
            lcg_state = lcg_next(lcg_state);
            sx = int'(lcg_state[23:16]) % `BOARD_DIM;
            sy = int'(lcg_state[31:24]) % `BOARD_DIM;
            if ((sx + sy) % 2 != 0)
                sy = (sy == `BOARD_DIM - 1) ? sy - 1 : sy + 1;   // Flip to even parity
            begin_test();
            start_tour(sx, sy);
            finish_tour(sx, sy);
            end_test($sformatf("random tour from (%0d,%0d)", sx, sy));
        end

        begin_test();
        start_tour(0, 1);
        finish_tour(0, 1);
        @(negedge clk);
        if (!tour_done)
            report_mismatch("tour_done low after an odd start finished");
        end_test("odd start (0,1)");

        begin_test();
        start_tour(2, 2);
        apb_write(`REG_START, 32'h10, err);     // A second go would run from (0,1)
        if (err)
            report_failure("write of START while busy was refused with an error response");
        apb_write(`REG_CTRL, 32'h1, err);
        if (!err)
            report_failure("go write while busy was accepted without an error response");
        finish_tour(2, 2);
        end_test("go while busy");

        begin_test();
        apb_read(`REG_START, start_before, err);
        apb_read(`REG_STATUS, status_before, err);
        apb_read(`REG_MOVE_BASE, move0_before, err);
        apb_read(8'h3c, rd, err);
        if (!err)
            report_failure("read of unmapped address 0x3c gave no error response");
        apb_read(8'(`REG_MOVE_BASE + 4 * `NUM_MOVES), rd, err);
        if (!err)
            report_failure("read beyond the last move gave no error response");
        apb_write(`REG_STATUS, 32'h33, err);
        if (!err)
            report_failure("write to STATUS gave no error response");
        apb_read(`REG_START, rd, err);
        if (rd != start_before)
            report_mismatch($sformatf("START changed to %08h", rd));
        apb_read(`REG_STATUS, rd, err);
        if (rd != status_before)
            report_mismatch($sformatf("STATUS changed to %08h", rd));
        apb_read(`REG_MOVE_BASE, rd, err);
        if (rd != move0_before)
            report_mismatch($sformatf("move 0 changed to %08h", rd));
        end_test("error responses");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== knight_tour_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module knight_tour_top (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    output logic         tour_done
);
    import knight_pkg::*;

    logic                 start, busy, done;
    logic [`COORD_W-1:0]  start_x, start_y;
    tour_result_t         result;
    logic [`COORD_W-1:0]  cur_x, cur_y, sq_x, sq_y;
    logic                 clear, mark, unmark;
    logic                 best_valid;
    move_code_t           best_jump, tried_mask;
    logic                 log_we, tried_set, tried_clr;
    logic [`STEP_W-1:0]   log_step, rd_step, rd_back_step;
    move_code_t           log_code, rd_code, back_code;

    tour_apb_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .busy, .done, .result, .rd_code,
        .prdata, .pready, .pslverr, .start, .start_x, .start_y, .rd_step
    );

    tour_logic u_logic (
        .clk, .rst_n, .start, .start_x, .start_y,
        .best_valid, .best_jump, .tried_mask, .back_code,
        .busy, .done, .result, .cur_x, .cur_y,
        .clear, .mark, .unmark, .sq_x, .sq_y,
        .log_we, .log_step, .log_code, .tried_set, .tried_clr, .rd_back_step
    );

    tour_board u_board (
        .clk, .rst_n, .clear, .mark, .unmark, .sq_x, .sq_y,
        .cur_x, .cur_y, .tried_mask,
        .legal_mask (),                          // Used inside the board only
        .best_valid, .best_jump
    );

    move_log u_log (
        .clk, .rst_n, .log_we, .log_step, .log_code,
        .tried_set, .tried_clr, .rd_step, .rd_back_step,
        .rd_code, .back_code, .tried_mask
    );

    assign tour_done = done;

endmodule

`default_nettype wire

// ==== move_log.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module move_log (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     log_we,
    input  logic [`STEP_W-1:0]       log_step,
    input  knight_pkg::move_code_t   log_code,
    input  logic                     tried_set,
    input  logic                     tried_clr,
    input  logic [`STEP_W-1:0]       rd_step,
    input  logic [`STEP_W-1:0]       rd_back_step,
    output knight_pkg::move_code_t   rd_code,
    output knight_pkg::move_code_t   back_code,
    output knight_pkg::move_code_t   tried_mask
);
    import knight_pkg::*;

    move_code_t codes [`STACK_DEPTH];
    move_code_t tried [`STACK_DEPTH];

    always_ff @(posedge clk) begin
        if (log_we && log_step < `STACK_DEPTH)
            codes[log_step] <= log_code;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `STACK_DEPTH; i++)
                tried[i] <= '0;
        end else if (log_step < `STACK_DEPTH) begin
            if (tried_clr)
                tried[log_step] <= '0;
            else if (tried_set)
                tried[log_step] <= tried[log_step] | log_code;
        end
    end

    // Out of range indices read as zero
    assign rd_code    = (rd_step < `STACK_DEPTH) ? codes[rd_step] : '0;
    assign back_code  = (rd_back_step < `STACK_DEPTH) ? codes[rd_back_step] : '0;
    assign tried_mask = (log_step < `STACK_DEPTH) ? tried[log_step] : '0;

    a_code_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        log_we |-> $onehot(log_code))
        else $error("logged move not one-hot");

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;   // 50% duty

endmodule

`default_nettype wire

// ==== tour_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module tour_apb_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [7:0]                  paddr,
    input  logic [31:0]                 pwdata,
    input  logic                        busy,
    input  logic                        done,
    input  knight_pkg::tour_result_t    result,
    input  knight_pkg::move_code_t      rd_code,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        start,
    output logic [`COORD_W-1:0]         start_x,
    output logic [`COORD_W-1:0]         start_y,
    output logic [`STEP_W-1:0]          rd_step
);
    import knight_pkg::*;

    logic       access;
    logic       in_window;
    logic [7:0] win_off;
    logic       addr_err, ro_err, go_err;
    logic       go_wr, start_wr;

    assign access    = psel && penable;
    assign win_off   = paddr - ADDR_MOVE_BASE;
    assign rd_step   = win_off[6:2];
    assign in_window = (paddr[1:0] == 2'b00) && (paddr >= ADDR_MOVE_BASE) &&
                       (paddr < ADDR_MOVE_BASE + 4 * `NUM_MOVES);

    always_comb begin
        prdata   = '0;
        addr_err = 1'b0;
        ro_err   = 1'b0;
        go_err   = 1'b0;
        go_wr    = 1'b0;
        start_wr = 1'b0;
        case (reg_addr_t'(paddr))
            ADDR_CTRL: begin                     // Go is write-only
                go_wr  = pwrite && pwdata[0];
                go_err = go_wr && busy;
            end
            ADDR_START: begin
                prdata   = {25'b0, start_y, 1'b0, start_x};
                start_wr = pwrite;
            end
            ADDR_STATUS: begin
                prdata = {26'b0, result, 2'b00, done, busy};
                ro_err = pwrite;
            end
            default: begin
                if (in_window) begin
                    prdata = {24'b0, rd_code};
                    ro_err = pwrite;
                end else begin
                    addr_err = 1'b1;
                end
            end
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access && (addr_err || ro_err || go_err);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start   <= 1'b0;
            start_x <= '0;
            start_y <= '0;
        end else begin
            start <= access && go_wr && !busy;
            if (access && start_wr) begin
                start_x <= pwdata[2:0];
                start_y <= pwdata[6:4];
            end
        end
    end

    // Solver must take the pulse and report busy right after
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy ##1 busy)
        else $error("start while solver busy");

endmodule

`default_nettype wire

// ==== tour_board.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module tour_board (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     mark,
    input  logic                     unmark,
    input  logic [`COORD_W-1:0]      sq_x,
    input  logic [`COORD_W-1:0]      sq_y,
    input  logic [`COORD_W-1:0]      cur_x,
    input  logic [`COORD_W-1:0]      cur_y,
    input  knight_pkg::move_code_t   tried_mask,
    output logic [7:0]               legal_mask,
    output logic                     best_valid,
    output knight_pkg::move_code_t   best_jump
);
    import knight_pkg::*;

    logic [`NUM_SQUARES-1:0] visited;
    logic signed [4:0]       nx [8];
    logic signed [4:0]       ny [8];
    logic [3:0]              deg [8];
    logic [7:0]              cand;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            visited <= '0;
        end else begin
            if (clear)
                visited <= '0;
            if (mark)
                visited[sq_index(sq_x, sq_y)] <= 1'b1;
            if (unmark)
                visited[sq_index(sq_x, sq_y)] <= 1'b0;
        end
    end

    // Destinations, legality and onward degree of each jump
    always_comb begin : degree_calc
        logic signed [4:0] mx;
        logic signed [4:0] my;
        for (int j = 0; j < 8; j++) begin
            nx[j] = $signed({2'b00, cur_x}) + jump_dx[j];
            ny[j] = $signed({2'b00, cur_y}) + jump_dy[j];
            legal_mask[j] = on_board(nx[j], ny[j]) &&
                            !visited[sq_index(nx[j][2:0], ny[j][2:0])];
            deg[j] = '0;
            for (int k = 0; k < 8; k++) begin
                mx = nx[j] + jump_dx[k];
                my = ny[j] + jump_dy[k];
                if (on_board(mx, my) && !visited[sq_index(mx[2:0], my[2:0])])
                    deg[j] = deg[j] + 4'd1;
            end
        end
    end

    assign cand = legal_mask & ~tried_mask;   // Legal and not yet tried at this step

    // Warnsdorff pick, strict compare keeps the lowest index on a tie
    always_comb begin : pick
        logic [3:0] min_deg;
        min_deg   = 4'd9;
        best_jump = '0;
        for (int j = 0; j < 8; j++) begin
            if (cand[j] && deg[j] < min_deg) begin
                min_deg   = deg[j];
                best_jump = 8'b1 << j;
            end
        end
        best_valid = |best_jump;
    end

    a_best_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        best_valid |-> $onehot(best_jump))
        else $error("best_jump not one-hot");

endmodule

`default_nettype wire

// ==== tour_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module tour_logic (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`COORD_W-1:0]         start_x,
    input  logic [`COORD_W-1:0]         start_y,
    input  logic                        best_valid,
    input  knight_pkg::move_code_t      best_jump,
    input  knight_pkg::move_code_t      tried_mask,
    input  knight_pkg::move_code_t      back_code,
    output logic                        busy,
    output logic                        done,
    output knight_pkg::tour_result_t    result,
    output logic [`COORD_W-1:0]         cur_x,
    output logic [`COORD_W-1:0]         cur_y,
    output logic                        clear,
    output logic                        mark,
    output logic                        unmark,
    output logic [`COORD_W-1:0]         sq_x,
    output logic [`COORD_W-1:0]         sq_y,
    output logic                        log_we,
    output logic [`STEP_W-1:0]          log_step,
    output knight_pkg::move_code_t      log_code,
    output logic                        tried_set,
    output logic                        tried_clr,
    output logic [`STEP_W-1:0]          rd_back_step
);
    import knight_pkg::*;

    localparam int CW = `COORD_W;

    solver_state_t       state;
    logic [`STEP_W-1:0]  step;         // Moves made so far
    logic [2:0]          best_idx;
    logic [2:0]          back_idx;
    logic [CW-1:0]       dest_x, dest_y;
    logic [CW-1:0]       orig_x, orig_y;
    logic                bad_start;

    assign best_idx = code_to_jump(best_jump);
    assign back_idx = code_to_jump(back_code);
    assign dest_x   = cur_x + CW'(jump_dx[best_idx]);
    assign dest_y   = cur_y + CW'(jump_dy[best_idx]);
    assign orig_x   = cur_x - CW'(jump_dx[back_idx]);   // Undo the jump into this square
    assign orig_y   = cur_y - CW'(jump_dy[back_idx]);

    // Odd colour or off-board start cannot hold an open tour
    assign bad_start = (cur_x[0] ^ cur_y[0]) || (cur_x >= `BOARD_DIM) || (cur_y >= `BOARD_DIM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            step   <= '0;
            cur_x  <= '0;
            cur_y  <= '0;
            result <= RES_NONE;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start) begin
                        state  <= S_INIT;
                        cur_x  <= start_x;
                        cur_y  <= start_y;
                        result <= RES_NONE;
                    end
                end
                S_INIT: begin
                    step <= '0;
                    if (bad_start) begin
                        state  <= S_DONE;
                        result <= RES_NO_TOUR;
                    end else begin
                        state <= S_SELECT;
                    end
                end
                S_SELECT: begin
                    if (best_valid) begin
                        cur_x <= dest_x;
                        cur_y <= dest_y;
                        state <= S_ADVANCE;
                    end else begin
                        state <= S_BACKTRACK;
                    end
                end
                S_ADVANCE: begin
                    step <= step + 1'b1;
                    if (step == `NUM_MOVES - 1) begin
                        state  <= S_DONE;
                        result <= RES_FOUND;
                    end else begin
                        state <= S_SELECT;
                    end
                end
                S_BACKTRACK: begin
                    if (step == '0) begin       // Search exhausted
                        state  <= S_DONE;
                        result <= RES_NO_TOUR;
                    end else begin
                        cur_x <= orig_x;
                        cur_y <= orig_y;
                        step  <= step - 1'b1;
                        state <= S_SELECT;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        clear     = 1'b0;
        mark      = 1'b0;
        unmark    = 1'b0;
        sq_x      = cur_x;
        sq_y      = cur_y;
        log_we    = 1'b0;
        tried_set = 1'b0;
        tried_clr = 1'b0;
        log_step  = step;
        case (state)
            S_INIT: begin
                log_step  = '0;
                clear     = !bad_start;
                mark      = !bad_start;          // Start square
                tried_clr = !bad_start;
            end
            S_SELECT: begin
                if (best_valid) begin
                    mark      = 1'b1;
                    sq_x      = dest_x;
                    sq_y      = dest_y;
                    log_we    = 1'b1;
                    tried_set = 1'b1;
                end
            end
            S_ADVANCE: begin
                log_step  = step + 1'b1;         // Fresh mask for the step entered
                tried_clr = (step != `NUM_MOVES - 1);
            end
            S_BACKTRACK: begin
                unmark    = (step != '0);
                tried_clr = (step != '0);        // Abandoned step
            end
            default: ;
        endcase
    end

    assign log_code     = best_jump;
    assign rd_back_step = step - 1'b1;
    assign busy         = (state != S_IDLE) && (state != S_DONE);
    assign done         = (state == S_DONE);

    a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
        step <= `NUM_MOVES)
        else $error("step count overflow");

    a_mark_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mark && unmark))
        else $error("mark and unmark together");

    // Board pick must respect the tried mask kept in the log
    a_untried: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_SELECT && best_valid) |-> (best_jump & tried_mask) == '0)
        else $error("selected an already tried jump");

endmodule

`default_nettype wire
